/* shift_params.svh */
`ifndef SHIFT_PARAMS_SVH
`define SHIFT_PARAMS_SVH

// Datapath widths.
`define WORD_W          32
`define PHY_REGS        46
`define REG_IDX_W       6
`define ALU_OP_W        5
`define SHAMT_W         8

// Destination index that names no register.
`define NO_REG          6'd63

// Shift codes, as issue encodes them.
`define SH_LSL          3'd0
`define SH_LSR          3'd1
`define SH_ASR          3'd2
`define SH_ROR          3'd3
`define SH_RRX          3'd4

// Never-execute condition, and the carry position in CPSR.
`define COND_NV         4'd15
`define CARRY_BIT       29

`endif

/* isa_pkg.sv */
`include "shift_params.svh"

// Instruction-level encodings seen by the shift stage.
package isa_pkg;

        ////////////////////
        // Opcodes.
        ////////////////////

        // Shift type, LSL through RRX.
        typedef logic [2:0]             shift_op_t;

        // ALU operation, carried through unchanged.
        typedef logic [`ALU_OP_W-1:0]   alu_op_t;

        // Condition field, NV means squashed.
        typedef logic [3:0]             cond_t;

endpackage

/* pipe_pkg.sv */
`include "shift_params.svh"

// Datapath types of the pipeline.
package pipe_pkg;

        ////////////////////
        // Values.
        ////////////////////

        // One data word.
        typedef logic [`WORD_W-1:0]     word_t;

        // Physical register index.
        typedef logic [`REG_IDX_W-1:0]  reg_idx_t;

        // Top bit set: low bits hold an immediate.
        // Top bit clear: low bits hold a register index.
        typedef logic [`WORD_W:0]       src_t;

        // Shift amount actually used by the shifter.
        typedef logic [`SHAMT_W-1:0]    shamt_t;

endpackage

/* operand_if.sv */
// Resolved operands of one instruction.
interface operand_if
        import pipe_pkg::*;
();

        word_t alu_operand;
        word_t shift_operand;
        word_t shift_amount;
        word_t store_value;

        // Forwarding unit drives all four.
        modport resolver (output alu_operand, shift_operand, shift_amount, store_value);

        // Shifter needs the source and the amount.
        modport shifter (input shift_operand, shift_amount);

        // Stage register latches what the ALU and memory use.
        modport stage (input alu_operand, shift_operand, store_value);

endinterface

/* operand_resolver.sv */
`include "shift_params.svh"

// Forwarding of the four operands of the issued instruction.
module operand_resolver
        import pipe_pkg::*;
(
        input  src_t            i_alu_source,
        input  word_t           i_alu_source_value,
        input  src_t            i_shift_source,
        input  word_t           i_shift_source_value,
        input  src_t            i_shift_length_source,
        input  word_t           i_shift_length_value,
        input  reg_idx_t        i_store_index,
        input  word_t           i_store_value,
        input  reg_idx_t        i_stage_dest,
        input  word_t           i_alu_value_nxt,
        input  logic            i_alu_dav_nxt,
        operand_if.resolver     opnd
);

// Register source matches the instruction now in the ALU.
function automatic logic is_hit(input src_t src, input reg_idx_t dest, input logic dav);
        return !src[`WORD_W] && (src[`REG_IDX_W-1:0] == dest) && dav;
endfunction

// Immediate first, then ALU bypass, then the issue read.
function automatic word_t pick(input src_t src, input logic hit, input word_t alu_value,
                               input word_t issue_value);
        if (src[`WORD_W])
                return src[`WORD_W-1:0];
        else if (hit)
                return alu_value;
        else
                return issue_value;
endfunction

logic alu_hit, shift_hit, length_hit, store_hit;
src_t store_src;

// Stores always name a register.
assign store_src  = src_t'(i_store_index);

assign alu_hit    = is_hit(i_alu_source, i_stage_dest, i_alu_dav_nxt);
assign shift_hit  = is_hit(i_shift_source, i_stage_dest, i_alu_dav_nxt);
assign length_hit = is_hit(i_shift_length_source, i_stage_dest, i_alu_dav_nxt);
assign store_hit  = is_hit(store_src, i_stage_dest, i_alu_dav_nxt);

assign opnd.alu_operand   = pick(i_alu_source, alu_hit, i_alu_value_nxt, i_alu_source_value);
assign opnd.shift_operand = pick(i_shift_source, shift_hit, i_alu_value_nxt,
                                 i_shift_source_value);
assign opnd.shift_amount  = pick(i_shift_length_source, length_hit, i_alu_value_nxt,
                                 i_shift_length_value);
assign opnd.store_value   = pick(store_src, store_hit, i_alu_value_nxt, i_store_value);

// A bypass must come from a real register, never the empty slot.
always_comb
begin
        if (alu_hit || shift_hit || length_hit || store_hit)
        begin
                assert final (i_stage_dest < `PHY_REGS && i_stage_dest != `NO_REG)
                else $error("forwarded from bad register index %0d", i_stage_dest);
        end
end

endmodule

/* barrel_shifter.sv */
`include "shift_params.svh"

// ARM barrel shifter with carry out.
module barrel_shifter
        import isa_pkg::*;
        import pipe_pkg::*;
(
        operand_if.shifter      opnd,
        input  shift_op_t       i_shift_op,
        input  logic            i_carry,
        output word_t           o_result,
        output logic            o_carry
);

localparam shamt_t FULL  = shamt_t'(`WORD_W);
localparam int     ROT_W = $clog2(`WORD_W);

shamt_t                 n;
word_t                  src;
logic [ROT_W-1:0]       rot;
logic [2*`WORD_W-1:0]   rot_wide;

// Only the low byte of the amount register counts.
assign n   = opnd.shift_amount[`SHAMT_W-1:0];
assign src = opnd.shift_operand;

// Rotate through a doubled word.
assign rot      = n[ROT_W-1:0];
assign rot_wide = {src, src} >> rot;

always_comb
begin
        // Zero amount passes operand and carry.
        o_result = src;
        o_carry  = i_carry;

        case (i_shift_op)
        `SH_LSL:
        begin
                if (n == '0)
                begin
                end
                else if (n < FULL)
                begin
                        o_result = src << n;
                        o_carry  = src[`WORD_W - n];
                end
                else
                begin
                        // Exactly 32 still shifts bit 0 into carry.
                        o_result = '0;
                        o_carry  = (n == FULL) ? src[0] : 1'b0;
                end
        end
        `SH_LSR:
        begin
                if (n == '0)
                begin
                end
                else if (n < FULL)
                begin
                        o_result = src >> n;
                        o_carry  = src[n - 1];
                end
                else
                begin
                        o_result = '0;
                        o_carry  = (n == FULL) ? src[`WORD_W-1] : 1'b0;
                end
        end
        `SH_ASR:
        begin
                if (n == '0)
                begin
                end
                else if (n < FULL)
                begin
                        o_result = $signed(src) >>> n;
                        o_carry  = src[n - 1];
                end
                else
                begin
                        // Saturates to the sign.
                        o_result = {`WORD_W{src[`WORD_W-1]}};
                        o_carry  = src[`WORD_W-1];
                end
        end
        `SH_ROR:
        begin
                if (n == '0)
                begin
                end
                else if (rot == '0)
                begin
                        // Multiple of 32.
                        o_carry = src[`WORD_W-1];
                end
                else
                begin
                        o_result = rot_wide[`WORD_W-1:0];
                        o_carry  = rot_wide[`WORD_W-1];
                end
        end
        `SH_RRX:
        begin
                // 33-bit rotate through carry, amount ignored.
                o_result = {i_carry, src[`WORD_W-1:1]};
                o_carry  = src[0];
        end
        default:
        begin
        end
        endcase
end

// Issue never emits codes past RRX.
always_comb
begin
        if (!$isunknown(i_shift_op))
        begin
                assert final (i_shift_op <= `SH_RRX)
                else $error("illegal shift code %0d", i_shift_op);
        end
end

endmodule

/* stage_register.sv */
`include "shift_params.svh"

// Result select and the shift stage output flops.
module stage_register
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_code_stall,
        input  logic            i_clear_from_writeback,
        input  logic            i_data_stall,
        input  logic            i_clear_from_alu,
        operand_if.stage        opnd,
        input  word_t           i_shift_result,
        input  logic            i_shift_carry,
        input  logic            i_disable_shifter,
        input  word_t           i_cpsr_nxt,
        input  cond_t           i_condition_code,
        input  reg_idx_t        i_destination_index,
        input  alu_op_t         i_alu_operation,
        input  logic            i_flag_update,
        output cond_t           o_condition_code,
        output reg_idx_t        o_destination_index,
        output alu_op_t         o_alu_operation,
        output logic            o_flag_update,
        output word_t           o_alu_source_value,
        output word_t           o_shifted_source_value,
        output logic            o_shift_carry,
        output word_t           o_mem_srcdest_value
);

word_t  shifted_nxt;
logic   carry_nxt;
logic   load;

////////////////////
// Result select.
////////////////////

// Bypassed shifter keeps the flag carry.
assign shifted_nxt = i_disable_shifter ? opnd.shift_operand : i_shift_result;
assign carry_nxt   = i_disable_shifter ? i_cpsr_nxt[`CARRY_BIT] : i_shift_carry;

// Load only when nothing stalls or clears.
assign load = !i_reset && !i_code_stall && !i_clear_from_writeback &&
              !i_data_stall && !i_clear_from_alu;

////////////////////
// Control flops.
////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_condition_code    <= `COND_NV;
                o_destination_index <= `NO_REG;
                o_flag_update       <= 1'b0;
        end
        else if (i_code_stall)
        begin
                // Hold.
        end
        else if (i_clear_from_writeback)
        begin
                o_condition_code    <= `COND_NV;
                o_destination_index <= `NO_REG;
                o_flag_update       <= 1'b0;
        end
        else if (i_data_stall)
        begin
                // Hold.
        end
        else if (i_clear_from_alu)
        begin
                o_condition_code    <= `COND_NV;
                o_destination_index <= `NO_REG;
                o_flag_update       <= 1'b0;
        end
        else
        begin
                o_condition_code    <= i_condition_code;
                o_destination_index <= i_destination_index;
                o_flag_update       <= i_flag_update;
        end
end

// Payload follows the same load, but a clear leaves it alone.
always_ff @(posedge i_clk)
begin
        if (load)
        begin
                o_alu_operation        <= i_alu_operation;
                o_alu_source_value     <= opnd.alu_operand;
                o_shifted_source_value <= shifted_nxt;
                o_shift_carry          <= carry_nxt;
                o_mem_srcdest_value    <= opnd.store_value;
        end
end

// Code stall freezes every output for the following cycle.
a_code_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        i_code_stall |=> $stable({o_condition_code, o_destination_index, o_flag_update,
                                  o_alu_operation, o_alu_source_value,
                                  o_shifted_source_value, o_shift_carry,
                                  o_mem_srcdest_value}))
else $error("stage register moved under code stall");

endmodule

/* shift_stage.sv */
`include "shift_params.svh"

// Shift stage: operand bypass, barrel shift, one register.
module shift_stage
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_code_stall,
        input  logic            i_clear_from_writeback,
        input  logic            i_data_stall,
        input  logic            i_clear_from_alu,
        input  src_t            i_alu_source,
        input  word_t           i_alu_source_value,
        input  src_t            i_shift_source,
        input  word_t           i_shift_source_value,
        input  src_t            i_shift_length_source,
        input  word_t           i_shift_length_value,
        input  reg_idx_t        i_store_index,
        input  word_t           i_store_value,
        input  word_t           i_alu_value_nxt,
        input  logic            i_alu_dav_nxt,
        input  shift_op_t       i_shift_op,
        input  logic            i_disable_shifter,
        input  word_t           i_cpsr_nxt,
        input  cond_t           i_condition_code,
        input  reg_idx_t        i_destination_index,
        input  alu_op_t         i_alu_operation,
        input  logic            i_flag_update,
        output cond_t           o_condition_code,
        output reg_idx_t        o_destination_index,
        output alu_op_t         o_alu_operation,
        output logic            o_flag_update,
        output word_t           o_alu_source_value,
        output word_t           o_shifted_source_value,
        output logic            o_shift_carry,
        output word_t           o_mem_srcdest_value
);

operand_if opnd ();

word_t  shift_result;
logic   shift_carry;

// Bypass against the instruction held in this stage.
operand_resolver u_resolver (
        .i_alu_source           (i_alu_source),
        .i_alu_source_value     (i_alu_source_value),
        .i_shift_source         (i_shift_source),
        .i_shift_source_value   (i_shift_source_value),
        .i_shift_length_source  (i_shift_length_source),
        .i_shift_length_value   (i_shift_length_value),
        .i_store_index          (i_store_index),
        .i_store_value          (i_store_value),
        .i_stage_dest           (o_destination_index),
        .i_alu_value_nxt        (i_alu_value_nxt),
        .i_alu_dav_nxt          (i_alu_dav_nxt),
        .opnd                   (opnd.resolver)
);

// Shifts the forwarded source by the forwarded amount.
barrel_shifter u_shifter (
        .opnd           (opnd.shifter),
        .i_shift_op     (i_shift_op),
        .i_carry        (i_cpsr_nxt[`CARRY_BIT]),
        .o_result       (shift_result),
        .o_carry        (shift_carry)
);

stage_register u_stage (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .opnd                   (opnd.stage),
        .i_shift_result         (shift_result),
        .i_shift_carry          (shift_carry),
        .i_disable_shifter      (i_disable_shifter),
        .i_cpsr_nxt             (i_cpsr_nxt),
        .i_condition_code       (i_condition_code),
        .i_destination_index    (i_destination_index),
        .i_alu_operation        (i_alu_operation),
        .i_flag_update          (i_flag_update),
        .o_condition_code       (o_condition_code),
        .o_destination_index    (o_destination_index),
        .o_alu_operation        (o_alu_operation),
        .o_flag_update          (o_flag_update),
        .o_alu_source_value     (o_alu_source_value),
        .o_shifted_source_value (o_shifted_source_value),
        .o_shift_carry          (o_shift_carry),
        .o_mem_srcdest_value    (o_mem_srcdest_value)
);

endmodule

/* tb_shift_stage.sv */
`include "shift_params.svh"

// Testbench for the shift stage.
module tb_shift_stage
        import isa_pkg::*;
        import pipe_pkg::*;
();

localparam int RESET_CYCLES = 10;
localparam int SHIFT_CYCLES = 400;
localparam int FWD_CYCLES   = 200;
localparam int DIS_CYCLES   = 100;
localparam int STALL_CYCLES = 300;
localparam int MAX_CYCLES   = RESET_CYCLES + SHIFT_CYCLES + FWD_CYCLES + DIS_CYCLES +
                              STALL_CYCLES + 50;

logic i_clk, i_reset;
logic i_code_stall, i_clear_from_writeback, i_data_stall, i_clear_from_alu;
src_t i_alu_source, i_shift_source, i_shift_length_source;
word_t i_alu_source_value, i_shift_source_value, i_shift_length_value;
reg_idx_t i_store_index, i_destination_index;
word_t i_store_value, i_alu_value_nxt, i_cpsr_nxt;
logic i_alu_dav_nxt, i_disable_shifter, i_flag_update;
shift_op_t i_shift_op;
cond_t i_condition_code;
alu_op_t i_alu_operation;
cond_t o_condition_code;
reg_idx_t o_destination_index;
alu_op_t o_alu_operation;
logic o_flag_update, o_shift_carry;
word_t o_alu_source_value, o_shifted_source_value, o_mem_srcdest_value;

// Expected register contents.
cond_t exp_cond;
reg_idx_t exp_dest;
logic exp_flag, exp_carry, exp_payload_valid, model_started;
alu_op_t exp_aluop;
word_t exp_alu, exp_shifted, exp_mem;

logic [31:0] lcg_state = 32'hea99;
reg_idx_t last_dest = '0;
int error_count = 0;
int check_count = 0;
int cycle_count = 0;

shift_stage dut (.*);

initial i_clk = 1'b0;
always #20 i_clk = ~i_clk;

////////////////////
// Stimulus helpers.
////////////////////

function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
endfunction

// Upper halves of two steps, the low bits of an LCG are weak.
task automatic next_rand(output logic [31:0] value);
        lcg_state = lcg_step(lcg_state);
        value[31:16] = lcg_state[31:16];
        lcg_state = lcg_step(lcg_state);
        value[15:0] = lcg_state[31:16];
endtask

// Amount biased to the edge cases, upper bits random.
task automatic pick_amount(output word_t amount);
        logic [31:0] r;
        logic [7:0] amt;
        next_rand(r);
        case (r[2:0])
        3'd0: amt = 8'd0;
        3'd1: amt = 8'd1;
        3'd2: amt = 8'd31;
        3'd3: amt = 8'd32;
        3'd4: amt = 8'd33;
        3'd5: amt = 8'd255;
        default: amt = r[15:8];
        endcase
        amount = {r[31:8], amt};
endtask

// Immediate, the last destination, or any real register.
task automatic pick_source(input logic use_fwd, output src_t src);
        logic [31:0] r;
        logic [31:0] imm;
        next_rand(r);
        next_rand(imm);
        if (r[1:0] == 2'd0)
                src = {1'b1, imm};
        else if (use_fwd && r[2])
                src = {27'd0, last_dest};
        else
                src = {27'd0, reg_idx_t'(r[15:8] % `PHY_REGS)};
endtask

task automatic drive_instruction(input logic use_fwd, input logic use_stalls,
                                 input logic disable_sh);
        src_t alu_src, sh_src, len_src;
        word_t amount, len_value;
        reg_idx_t store_idx, dest;
        logic [31:0] r0, r1, r2, r3, r4, r5, r6;
        pick_source(use_fwd, alu_src);
        pick_source(use_fwd, sh_src);
        pick_amount(amount);
        pick_amount(len_value);
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        next_rand(r3);
        next_rand(r4);
        next_rand(r5);
        next_rand(r6);
        if (r0[0])
                len_src = {1'b1, amount};
        else
                pick_source(use_fwd, len_src);
        store_idx = (use_fwd && r0[1]) ? last_dest : reg_idx_t'(r0[15:8] % `PHY_REGS);
        dest      = reg_idx_t'(r0[23:16] % `PHY_REGS);
        i_alu_source           <= alu_src;
        i_alu_source_value     <= r1;
        i_shift_source         <= sh_src;
        i_shift_source_value   <= r2;
        i_shift_length_source  <= len_src;
        i_shift_length_value   <= len_value;
        i_store_index          <= store_idx;
        i_store_value          <= r3;
        i_alu_value_nxt        <= r4;
        i_alu_dav_nxt          <= r0[2];
        i_shift_op             <= shift_op_t'(r0[31:24] % 5);
        i_disable_shifter      <= disable_sh;
        i_cpsr_nxt             <= r5;
        i_condition_code       <= r6[3:0];
        i_alu_operation        <= r6[8:4];
        i_flag_update          <= r6[9];
        i_destination_index    <= dest;
        // Each stall or clear is active about a quarter of the time.
        i_code_stall           <= use_stalls && (r6[13:12] == 2'd0);
        i_clear_from_writeback <= use_stalls && (r6[15:14] == 2'd0);
        i_data_stall           <= use_stalls && (r6[17:16] == 2'd0);
        i_clear_from_alu       <= use_stalls && (r6[19:18] == 2'd0);
        last_dest = dest;
endtask

////////////////////
// Reference model.
////////////////////

function automatic word_t forward_ref(input src_t src, input word_t issue_value,
                                      input reg_idx_t held_dest, input word_t alu_value,
                                      input logic alu_valid);
        if (src[32])
                return src[31:0];
        else if (alu_valid && src[5:0] == held_dest)
                return alu_value;
        else
                return issue_value;
endfunction

// Returns carry and result.
function automatic logic [32:0] shift_ref(input shift_op_t op, input word_t x,
                                          input shamt_t n, input logic cin);
        logic [63:0] wide;
        logic [4:0] r;
        word_t rot;
        logic [32:0] res;
        res = {cin, x};
        r = n[4:0];
        case (op)
        `SH_LSL:
        begin
                // Bit 32 of the widened word is the last bit shifted out.
                wide = {32'd0, x} << n;
                if (n != 0)
                        res = {wide[32], wide[31:0]};
        end
        `SH_LSR:
        begin
                wide = {x, 32'd0} >> n;
                if (n != 0)
                        res = {wide[31], wide[63:32]};
        end
        `SH_ASR:
        begin
                wide = $signed({x, 32'd0}) >>> ((n > 32) ? 32 : n);
                if (n != 0)
                        res = {wide[31], wide[63:32]};
        end
        `SH_ROR:
        begin
                rot = (x >> r) | (x << (32 - r));
                if (n != 0 && r == 0)
                        res = {x[31], x};
                else if (n != 0)
                        res = {rot[31], rot};
        end
        `SH_RRX: res = {x[0], cin, x[31:1]};
        default: res = {cin, x};
        endcase
        return res;
endfunction

always @(posedge i_clk)
begin : reference_model
        word_t alu_v, sh_v, amt_v, st_v, sel_value;
        logic [32:0] shifted;
        logic sel_carry;
        alu_v = forward_ref(i_alu_source, i_alu_source_value, exp_dest, i_alu_value_nxt,
                            i_alu_dav_nxt);
        sh_v  = forward_ref(i_shift_source, i_shift_source_value, exp_dest, i_alu_value_nxt,
                            i_alu_dav_nxt);
        amt_v = forward_ref(i_shift_length_source, i_shift_length_value, exp_dest,
                            i_alu_value_nxt, i_alu_dav_nxt);
        st_v  = forward_ref({27'd0, i_store_index}, i_store_value, exp_dest, i_alu_value_nxt,
                            i_alu_dav_nxt);
        shifted   = shift_ref(i_shift_op, sh_v, amt_v[7:0], i_cpsr_nxt[`CARRY_BIT]);
        sel_value = i_disable_shifter ? sh_v : shifted[31:0];
        sel_carry = i_disable_shifter ? i_cpsr_nxt[`CARRY_BIT] : shifted[32];
        model_started <= 1'b1;
        // Priority: reset, code stall, writeback clear, data stall, ALU clear.
        if (i_reset || (!i_code_stall && i_clear_from_writeback) ||
            (!i_code_stall && !i_data_stall && i_clear_from_alu))
        begin
                exp_cond <= `COND_NV;
                exp_dest <= `NO_REG;
                exp_flag <= 1'b0;
        end
        else if (!i_code_stall && !i_data_stall)
        begin
                exp_cond          <= i_condition_code;
                exp_dest          <= i_destination_index;
                exp_flag          <= i_flag_update;
                exp_aluop         <= i_alu_operation;
                exp_alu           <= alu_v;
                exp_shifted       <= sel_value;
                exp_carry         <= sel_carry;
                exp_mem           <= st_v;
                exp_payload_valid <= 1'b1;
        end
end

////////////////////
// Checker.
////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        check_count++;
        assert (got === expected)
        else
        begin
                error_count++;
                $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expected, got);
        end
endtask

// Outputs settle at the rising edge, compared half a cycle later.
always @(negedge i_clk)
begin
        if (model_started)
        begin
                check_value("o_condition_code", o_condition_code, exp_cond);
                check_value("o_destination_index", o_destination_index, exp_dest);
                check_value("o_flag_update", o_flag_update, exp_flag);
                if (exp_payload_valid)
                begin
                        check_value("o_alu_operation", o_alu_operation, exp_aluop);
                        check_value("o_alu_source_value", o_alu_source_value, exp_alu);
                        check_value("o_shifted_source_value", o_shifted_source_value,
                                    exp_shifted);
                        check_value("o_shift_carry", o_shift_carry, exp_carry);
                        check_value("o_mem_srcdest_value", o_mem_srcdest_value, exp_mem);
                end
        end
end

always @(posedge i_clk)
begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
                $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                $display("*** TEST FAILED ***");
                $finish;
        end
end

////////////////////
// Test sequence.
////////////////////

initial
begin
        model_started = 1'b0;
        exp_payload_valid = 1'b0;
        i_reset = 1'b1;
        i_code_stall = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall = 1'b0;
        i_clear_from_alu = 1'b0;
        i_alu_source = '0;
        i_alu_source_value = '0;
        i_shift_source = '0;
        i_shift_source_value = '0;
        i_shift_length_source = '0;
        i_shift_length_value = '0;
        i_store_index = '0;
        i_store_value = '0;
        i_alu_value_nxt = '0;
        i_alu_dav_nxt = 1'b0;
        i_shift_op = `SH_LSL;
        i_disable_shifter = 1'b0;
        i_cpsr_nxt = '0;
        i_condition_code = '0;
        i_destination_index = '0;
        i_alu_operation = '0;
        i_flag_update = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        // Control outputs idle after reset.
        @(negedge i_clk);
        check_value("o_condition_code", o_condition_code, 32'd15);
        check_value("o_destination_index", o_destination_index, 32'd63);
        check_value("o_flag_update", o_flag_update, 32'd0);
        repeat (SHIFT_CYCLES)
        begin
                @(posedge i_clk);
                drive_instruction(1'b0, 1'b0, 1'b0);
        end
        repeat (FWD_CYCLES)
        begin
                @(posedge i_clk);
                drive_instruction(1'b1, 1'b0, 1'b0);
        end
        repeat (DIS_CYCLES)
        begin
                @(posedge i_clk);
                drive_instruction(1'b1, 1'b0, 1'b1);
        end
        repeat (STALL_CYCLES)
        begin
                @(posedge i_clk);
                drive_instruction(1'b1, 1'b1, lcg_state[31]);
        end
        repeat (2) @(negedge i_clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
                $display("*** TEST PASSED ***");
        else
                $display("*** TEST FAILED ***");
        $finish;
end

endmodule

/* all.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
operand_if.sv
operand_resolver.sv
barrel_shifter.sv
stage_register.sv
shift_stage.sv
tb_shift_stage.sv

/* Bender.yml */
package:
  name: shift_stage

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - operand_if.sv
      - operand_resolver.sv
      - barrel_shifter.sv
      - stage_register.sv
      - shift_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_shift_stage.sv
